/* Makefile */
# Verilator simulation of the reset and clock controller

VERILATOR ?= verilator
TOP       ?= rcc_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
hw/rcc_pkg.sv
hw/rcc_rst_if.sv
hw/rcc_reset_seq.sv
hw/rcc_stop_req.sv
hw/rcc_clk_enable.sv
hw/rcc_clk_rst_ctrl.sv
verification/rcc_rst_chk.sv
verification/rcc_tb.sv

/* hw/rcc_clk_enable.sv */
`timescale 1ns/1ps
`default_nettype none

module rcc_clk_enable (
  rcc_rst_if.gate                         rst,
  input  logic                            i_d1_req,
  input  logic                            i_d2_req,
  input  logic                            i_d3_req,
  input  logic                            i_c1_sleep,
  input  logic                            i_c1_deepsleep,
  input  logic                            i_c2_sleep,
  input  logic                            i_c2_deepsleep,
  input  logic [rcc_pkg::NUM_ALLOC-1:0]   i_c1_alloc,
  input  logic [rcc_pkg::NUM_ALLOC-1:0]   i_c2_alloc,
  input  logic [rcc_pkg::NUM_BUSY-1:0]    i_busy,
  output logic                            o_sys_clk_en,
  output logic                            o_c1_clk_en,
  output logic                            o_c2_clk_en,
  output logic [rcc_pkg::NUM_BRIDGES-1:0] o_bridge_clk_en
);

  logic sys_on;
  logic d1_on;
  logic d2_on;
  logic cpu1_on;
  logic cpu2_on;
  logic sys_en;
  logic d1_bus_en;
  logic d2_bus_en;
  logic d3_bus_en;
  logic sleepmode1;
  logic sleepmode2;
  logic axi_en;
  logic ahb3_en;
  logic apb3_en;
  logic ahb1_en;
  logic ahb2_en;
  logic apb1_en;
  logic apb2_en;

  // bridge stays on for its owner awake, either cpu in light sleep with
  // the bus allocated, or a transfer still in flight
  function automatic logic bridge_on(input logic own_awake, input logic own_sm,
                                     input logic own_alloc, input logic oth_sm,
                                     input logic oth_alloc, input logic busy);
    return own_awake || (own_sm && own_alloc) || (oth_sm && oth_alloc) || busy;
  endfunction

  // flags only count while their reset is released
  assign sys_on  = rst.sys_rst_n && rst.sys_clk_on;
  assign d1_on   = rst.d1_rst_n && rst.d1_clk_on;
  assign d2_on   = rst.d2_rst_n && rst.d2_clk_on;
  assign cpu1_on = rst.cpu1_rst_n && rst.cpu1_clk_on;
  assign cpu2_on = rst.cpu2_rst_n && rst.cpu2_clk_on;

  // ========================================
  // system, cpu and domain bus enables
  // ========================================
  assign sys_en      = !i_d3_req && sys_on;
  assign o_c1_clk_en = !i_c1_sleep && !i_c1_deepsleep && cpu1_on;
  assign o_c2_clk_en = !i_c2_sleep && !i_c2_deepsleep && cpu2_on;

  // bus clock off while its stop request is pending
  assign d1_bus_en = !i_d1_req && d1_on;
  assign d2_bus_en = !i_d2_req && d2_on;
  assign d3_bus_en = sys_en;

  // plain sleep, not deepsleep
  assign sleepmode1 = i_c1_sleep && !i_c1_deepsleep;
  assign sleepmode2 = i_c2_sleep && !i_c2_deepsleep;

  // ========================================
  // d2 bridges, owned by c2
  // ========================================
  assign apb1_en = d2_bus_en && bridge_on(!i_c2_sleep, sleepmode2, i_c2_alloc[rcc_pkg::ALLOC_APB1],
                   sleepmode1, i_c1_alloc[rcc_pkg::ALLOC_APB1], i_busy[rcc_pkg::BUSY_APB1_D2]);
  assign apb2_en = d2_bus_en && bridge_on(!i_c2_sleep, sleepmode2, i_c2_alloc[rcc_pkg::ALLOC_APB2],
                   sleepmode1, i_c1_alloc[rcc_pkg::ALLOC_APB2], i_busy[rcc_pkg::BUSY_APB2_D2]);
  assign ahb2_en = d2_bus_en && bridge_on(!i_c2_sleep, sleepmode2, i_c2_alloc[rcc_pkg::ALLOC_AHB2],
                   sleepmode1, i_c1_alloc[rcc_pkg::ALLOC_AHB2], i_busy[rcc_pkg::BUSY_AHB2_D2]);
  // apb1 and apb2 hang off ahb1
  assign ahb1_en = d2_bus_en && (apb1_en || apb2_en ||
                   bridge_on(!i_c2_sleep, sleepmode2, i_c2_alloc[rcc_pkg::ALLOC_AHB1],
                   sleepmode1, i_c1_alloc[rcc_pkg::ALLOC_AHB1], i_busy[rcc_pkg::BUSY_AHB1_D2]));

  // ========================================
  // d1 bridges, owned by c1
  // ========================================
  assign apb3_en = d1_bus_en && bridge_on(!i_c1_sleep, sleepmode1, i_c1_alloc[rcc_pkg::ALLOC_APB3],
                   sleepmode2, i_c2_alloc[rcc_pkg::ALLOC_APB3], i_busy[rcc_pkg::BUSY_APB3_D1]);
  // apb3 sits behind ahb3, flash too
  assign ahb3_en = d1_bus_en && (apb3_en || i_busy[rcc_pkg::BUSY_FLASH] ||
                   bridge_on(!i_c1_sleep, sleepmode1, i_c1_alloc[rcc_pkg::ALLOC_AHB3],
                   sleepmode2, i_c2_alloc[rcc_pkg::ALLOC_AHB3], i_busy[rcc_pkg::BUSY_AHB3_D1]));
  assign axi_en  = d1_bus_en && (!i_c1_sleep || i_busy[rcc_pkg::BUSY_AXI_D1]);

  assign o_sys_clk_en = sys_en;

  assign o_bridge_clk_en[rcc_pkg::BUSY_AXI_D1]  = axi_en;
  assign o_bridge_clk_en[rcc_pkg::BUSY_AHB3_D1] = ahb3_en;
  assign o_bridge_clk_en[rcc_pkg::BUSY_APB3_D1] = apb3_en;
  assign o_bridge_clk_en[rcc_pkg::BUSY_AHB1_D2] = ahb1_en;
  assign o_bridge_clk_en[rcc_pkg::BUSY_AHB2_D2] = ahb2_en;
  assign o_bridge_clk_en[rcc_pkg::BUSY_APB1_D2] = apb1_en;
  assign o_bridge_clk_en[rcc_pkg::BUSY_APB2_D2] = apb2_en;
  // d3 bridges just follow the system enable
  assign o_bridge_clk_en[rcc_pkg::BUSY_AHB4_D3] = d3_bus_en;
  assign o_bridge_clk_en[rcc_pkg::BUSY_APB4_D3] = d3_bus_en;

endmodule

`default_nettype wire

/* hw/rcc_clk_rst_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rcc_clk_rst_ctrl #(
  parameter int D1_RST_CYCLES = rcc_pkg::D1_RST_CYCLES,
  parameter int D2_RST_CYCLES = rcc_pkg::D2_RST_CYCLES,
  parameter int CLK_ON_DELAY  = rcc_pkg::CLK_ON_DELAY
) (
  input  logic                            i_clk,
  input  logic                            i_reset,
  // reset sources and readiness
  input  logic                            i_nrst,
  input  logic                            i_por_rst,
  input  logic                            i_vcore_ok,
  input  logic                            i_obl_done,
  input  logic                            i_hsi_rdy,
  input  logic                            i_flash_power_ok,
  input  logic                            i_d1_ok,
  input  logic                            i_d2_ok,
  input  logic                            i_wwdg1_rst,
  input  logic                            i_wwdg2_rst,
  input  logic                            i_arcg_on,
  // cpu low-power state
  input  logic                            i_c1_sleep,
  input  logic                            i_c1_deepsleep,
  input  logic                            i_c2_sleep,
  input  logic                            i_c2_deepsleep,
  input  logic                            i_d3_deepsleep,
  input  logic                            i_c1_alloc_d2,
  input  logic                            i_c2_alloc_d1,
  // power controller wakeups
  input  logic                            i_d1_wkup,
  input  logic                            i_d2_wkup,
  input  logic                            i_d3_wkup,
  input  logic [rcc_pkg::NUM_BUSY-1:0]    i_busy,
  input  logic [rcc_pkg::NUM_ALLOC-1:0]   i_c1_alloc,
  input  logic [rcc_pkg::NUM_ALLOC-1:0]   i_c2_alloc,
  output logic                            o_sys_rst_n,
  output logic                            o_d1_rst_n,
  output logic                            o_d2_rst_n,
  output logic                            o_cpu1_rst_n,
  output logic                            o_cpu2_rst_n,
  output logic                            o_d1_bus_rst_n,
  output logic                            o_d2_bus_rst_n,
  output logic                            o_d3_bus_rst_n,
  // stop requests to the power controller
  output logic                            o_d1_req,
  output logic                            o_d2_req,
  output logic                            o_d3_req,
  output logic                            o_sys_clk_en,
  output logic                            o_c1_clk_en,
  output logic                            o_c2_clk_en,
  output logic [rcc_pkg::NUM_BRIDGES-1:0] o_bridge_clk_en
);

  rcc_rst_if rst_bus ();

  rcc_reset_seq #(
    .D1_RST_CYCLES (D1_RST_CYCLES),
    .D2_RST_CYCLES (D2_RST_CYCLES),
    .CLK_ON_DELAY  (CLK_ON_DELAY)
  ) u_reset_seq (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_nrst           (i_nrst),
    .i_por_rst        (i_por_rst),
    .i_vcore_ok       (i_vcore_ok),
    .i_obl_done       (i_obl_done),
    .i_hsi_rdy        (i_hsi_rdy),
    .i_flash_power_ok (i_flash_power_ok),
    .i_d1_ok          (i_d1_ok),
    .i_d2_ok          (i_d2_ok),
    .i_wwdg1_rst      (i_wwdg1_rst),
    .i_wwdg2_rst      (i_wwdg2_rst),
    .i_arcg_on        (i_arcg_on),
    .rst              (rst_bus.seq)
  );

  rcc_stop_req u_stop_req (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_c1_deepsleep (i_c1_deepsleep),
    .i_c2_deepsleep (i_c2_deepsleep),
    .i_d3_deepsleep (i_d3_deepsleep),
    .i_c1_alloc_d2  (i_c1_alloc_d2),
    .i_c2_alloc_d1  (i_c2_alloc_d1),
    .i_busy         (i_busy),
    .i_d1_wkup      (i_d1_wkup),
    .i_d2_wkup      (i_d2_wkup),
    .i_d3_wkup      (i_d3_wkup),
    .o_d1_req       (o_d1_req),
    .o_d2_req       (o_d2_req),
    .o_d3_req       (o_d3_req)
  );

  // enables see the requests as registered outputs
  rcc_clk_enable u_clk_enable (
    .rst             (rst_bus.gate),
    .i_d1_req        (o_d1_req),
    .i_d2_req        (o_d2_req),
    .i_d3_req        (o_d3_req),
    .i_c1_sleep      (i_c1_sleep),
    .i_c1_deepsleep  (i_c1_deepsleep),
    .i_c2_sleep      (i_c2_sleep),
    .i_c2_deepsleep  (i_c2_deepsleep),
    .i_c1_alloc      (i_c1_alloc),
    .i_c2_alloc      (i_c2_alloc),
    .i_busy          (i_busy),
    .o_sys_clk_en    (o_sys_clk_en),
    .o_c1_clk_en     (o_c1_clk_en),
    .o_c2_clk_en     (o_c2_clk_en),
    .o_bridge_clk_en (o_bridge_clk_en)
  );

  assign o_sys_rst_n  = rst_bus.sys_rst_n;
  assign o_d1_rst_n   = rst_bus.d1_rst_n;
  assign o_d2_rst_n   = rst_bus.d2_rst_n;
  assign o_cpu1_rst_n = rst_bus.cpu1_rst_n;
  assign o_cpu2_rst_n = rst_bus.cpu2_rst_n;

  // bus resets need the system reset released as well
  assign o_d1_bus_rst_n = rst_bus.sys_rst_n && rst_bus.d1_rst_n;
  assign o_d2_bus_rst_n = rst_bus.sys_rst_n && rst_bus.d2_rst_n;
  assign o_d3_bus_rst_n = rst_bus.sys_rst_n;

endmodule

`default_nettype wire

/* hw/rcc_pkg.sv */
`default_nettype none

package rcc_pkg;

  // ========================================
  // default durations in i_clk cycles
  // ========================================
  // domain reset hold after power ok
  localparam int D1_RST_CYCLES = 10;
  localparam int D2_RST_CYCLES = 10;
  // clock stays off this long after reset release
  localparam int CLK_ON_DELAY  = 8;

  // ========================================
  // bridge busy flags
  // ========================================
  localparam int NUM_BUSY      = 10;
  localparam int BUSY_AXI_D1   = 0;
  localparam int BUSY_AHB3_D1  = 1;
  localparam int BUSY_APB3_D1  = 2;
  localparam int BUSY_AHB1_D2  = 3;
  localparam int BUSY_AHB2_D2  = 4;
  localparam int BUSY_APB1_D2  = 5;
  localparam int BUSY_APB2_D2  = 6;
  localparam int BUSY_AHB4_D3  = 7;
  localparam int BUSY_APB4_D3  = 8;
  // flash sits in d1, no bridge enable of its own
  localparam int BUSY_FLASH    = 9;

  // bridge enables share the first nine busy positions
  localparam int NUM_BRIDGES   = 9;

  // per-cpu peripheral allocation
  localparam int NUM_ALLOC     = 6;
  localparam int ALLOC_AHB1    = 0;
  localparam int ALLOC_AHB2    = 1;
  localparam int ALLOC_AHB3    = 2;
  localparam int ALLOC_APB1    = 3;
  localparam int ALLOC_APB2    = 4;
  localparam int ALLOC_APB3    = 5;

endpackage

`default_nettype wire

/* hw/rcc_reset_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module rcc_reset_seq #(
  parameter int D1_RST_CYCLES = rcc_pkg::D1_RST_CYCLES,
  parameter int D2_RST_CYCLES = rcc_pkg::D2_RST_CYCLES,
  parameter int CLK_ON_DELAY  = rcc_pkg::CLK_ON_DELAY
) (
  input  logic   i_clk,
  input  logic   i_reset,
  input  logic   i_nrst,
  input  logic   i_por_rst,
  input  logic   i_vcore_ok,
  input  logic   i_obl_done,
  input  logic   i_hsi_rdy,
  input  logic   i_flash_power_ok,
  input  logic   i_d1_ok,
  input  logic   i_d2_ok,
  input  logic   i_wwdg1_rst,
  input  logic   i_wwdg2_rst,
  input  logic   i_arcg_on,
  rcc_rst_if.seq rst
);

  // counter widths sized to hold the terminal value
  localparam int DOM_MAX = (D1_RST_CYCLES > D2_RST_CYCLES) ? D1_RST_CYCLES : D2_RST_CYCLES;
  localparam int DOM_W   = $clog2(DOM_MAX + 1);
  localparam int CON_W   = $clog2(CLK_ON_DELAY + 1);
  localparam logic [CON_W-1:0] CON_END = CON_W'(CLK_ON_DELAY);

  logic       hw_init_done;
  logic       sys_rst_n_q;
  logic       cpu1_rst_n;
  logic       cpu2_rst_n;
  // index 0 is d1, index 1 is d2
  logic [1:0] dom_ok;
  logic [1:0] dom_rel_en;
  logic [1:0] dom_rst_n;
  // sys, d1, d2, cpu1, cpu2 from bit 0 up
  logic [4:0] src_rst_n;
  logic [4:0] clk_on;

  // ========================================
  // system reset
  // ========================================
  assign hw_init_done = !i_por_rst && i_vcore_ok && i_obl_done;

  // held low until hw init done and pin released
  always_ff @(posedge i_clk) begin
    if (i_reset || !i_nrst || !hw_init_done) begin
      sys_rst_n_q <= 1'b0;
    end else begin
      sys_rst_n_q <= i_hsi_rdy && i_flash_power_ok;
    end
  end

  // ========================================
  // domain resets
  // ========================================
  assign dom_ok     = {i_d2_ok, i_d1_ok};
  // flash lives in d1 so d1 also waits for flash power
  assign dom_rel_en = {1'b1, i_flash_power_ok};

  for (genvar g = 0; g < 2; g++) begin : g_dom
    localparam logic [DOM_W-1:0] DOM_END = DOM_W'((g == 0) ? D1_RST_CYCLES : D2_RST_CYCLES);
    logic [DOM_W-1:0] cnt_q;
    logic             rst_n_q;

    // count up while power ok, park at the end value
    always_ff @(posedge i_clk) begin
      if (i_reset || !dom_ok[g]) begin
        cnt_q   <= '0;
        rst_n_q <= 1'b0;
      end else begin
        if (cnt_q != DOM_END) begin
          cnt_q <= cnt_q + DOM_W'(1);
        end
        if (dom_rel_en[g]) begin
          rst_n_q <= (cnt_q == DOM_END);
        end
      end
    end

    assign dom_rst_n[g] = rst_n_q;
  end

  // cpu resets also drop on watchdog
  assign cpu1_rst_n = sys_rst_n_q && dom_rst_n[0] && !i_wwdg1_rst;
  assign cpu2_rst_n = sys_rst_n_q && dom_rst_n[1] && !i_wwdg2_rst;

  // ========================================
  // clock-on delay after reset release
  // ========================================
  assign src_rst_n = {cpu2_rst_n, cpu1_rst_n, dom_rst_n[1], dom_rst_n[0], sys_rst_n_q};

  for (genvar k = 0; k < 5; k++) begin : g_con
    logic [CON_W-1:0] cnt_q;

    always_ff @(posedge i_clk) begin
      if (i_reset || !src_rst_n[k]) begin
        cnt_q <= '0;
      end else if (cnt_q != CON_END) begin
        cnt_q <= cnt_q + CON_W'(1);
      end
    end

    // arcg off means the clock follows the reset directly
    assign clk_on[k] = src_rst_n[k] && (!i_arcg_on || (cnt_q == CON_END));
  end

  assign rst.sys_rst_n   = sys_rst_n_q;
  assign rst.d1_rst_n    = dom_rst_n[0];
  assign rst.d2_rst_n    = dom_rst_n[1];
  assign rst.cpu1_rst_n  = cpu1_rst_n;
  assign rst.cpu2_rst_n  = cpu2_rst_n;
  assign rst.sys_clk_on  = clk_on[0];
  assign rst.d1_clk_on   = clk_on[1];
  assign rst.d2_clk_on   = clk_on[2];
  assign rst.cpu1_clk_on = clk_on[3];
  assign rst.cpu2_clk_on = clk_on[4];

endmodule

`default_nettype wire

/* hw/rcc_rst_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface rcc_rst_if;

  // active-low resets
  logic sys_rst_n;
  logic d1_rst_n;
  logic d2_rst_n;
  logic cpu1_rst_n;
  logic cpu2_rst_n;

  // high once the delay after reset release has run out
  logic sys_clk_on;
  logic d1_clk_on;
  logic d2_clk_on;
  logic cpu1_clk_on;
  logic cpu2_clk_on;

  // reset sequencer side
  modport seq (
    output sys_rst_n, d1_rst_n, d2_rst_n, cpu1_rst_n, cpu2_rst_n,
    output sys_clk_on, d1_clk_on, d2_clk_on, cpu1_clk_on, cpu2_clk_on
  );

  // clock enable side
  modport gate (
    input sys_rst_n, d1_rst_n, d2_rst_n, cpu1_rst_n, cpu2_rst_n,
    input sys_clk_on, d1_clk_on, d2_clk_on, cpu1_clk_on, cpu2_clk_on
  );

endinterface

`default_nettype wire

/* hw/rcc_stop_req.sv */
`timescale 1ns/1ps
`default_nettype none

module rcc_stop_req (
  input  logic                         i_clk,
  input  logic                         i_reset,
  input  logic                         i_c1_deepsleep,
  input  logic                         i_c2_deepsleep,
  input  logic                         i_d3_deepsleep,
  input  logic                         i_c1_alloc_d2,
  input  logic                         i_c2_alloc_d1,
  input  logic [rcc_pkg::NUM_BUSY-1:0] i_busy,
  input  logic                         i_d1_wkup,
  input  logic                         i_d2_wkup,
  input  logic                         i_d3_wkup,
  output logic                         o_d1_req,
  output logic                         o_d2_req,
  output logic                         o_d3_req
);

  logic       d1_busy;
  logic       d2_busy;
  logic       d3_busy;
  // bit 0 d1, bit 1 d2, bit 2 d3
  logic [2:0] req_set;
  logic [2:0] wkup;
  logic [2:0] req_q;

  // ========================================
  // domain busy
  // ========================================
  // flash counts toward d1
  assign d1_busy = i_busy[rcc_pkg::BUSY_AXI_D1] || i_busy[rcc_pkg::BUSY_AHB3_D1] ||
                   i_busy[rcc_pkg::BUSY_APB3_D1] || i_busy[rcc_pkg::BUSY_FLASH];
  assign d2_busy = i_busy[rcc_pkg::BUSY_AHB1_D2] || i_busy[rcc_pkg::BUSY_AHB2_D2] ||
                   i_busy[rcc_pkg::BUSY_APB1_D2] || i_busy[rcc_pkg::BUSY_APB2_D2];
  // d3 serves both other domains
  assign d3_busy = d1_busy || d2_busy ||
                   i_busy[rcc_pkg::BUSY_AHB4_D3] || i_busy[rcc_pkg::BUSY_APB4_D3];

  // ========================================
  // stop conditions
  // ========================================
  // c1 stopped and c2 either stopped or owns nothing in d1
  assign req_set[0] = i_c1_deepsleep && (!i_c2_alloc_d1 || i_c2_deepsleep) && !d1_busy;
  // mirror for d2
  assign req_set[1] = i_c2_deepsleep && (!i_c1_alloc_d2 || i_c1_deepsleep) && !d2_busy;
  // whole system stop
  assign req_set[2] = i_c1_deepsleep && i_c2_deepsleep && i_d3_deepsleep && !d3_busy;

  assign wkup = {i_d3_wkup, i_d2_wkup, i_d1_wkup};

  // request holds until wakeup, set beats wakeup
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      req_q <= '0;
    end else begin
      req_q <= req_set | (req_q & ~wkup);
    end
  end

  assign o_d1_req = req_q[0];
  assign o_d2_req = req_q[1];
  assign o_d3_req = req_q[2];

endmodule

`default_nettype wire

/* verification/rcc_rst_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module rcc_rst_chk (
  input wire                         i_clk,
  input wire                         i_reset,
  input wire                         i_c1_deepsleep,
  input wire                         i_c2_deepsleep,
  input wire                         i_c2_alloc_d1,
  input wire [rcc_pkg::NUM_BUSY-1:0] i_busy,
  input wire                         o_sys_rst_n,
  input wire                         o_cpu1_rst_n,
  input wire                         o_cpu2_rst_n,
  input wire                         o_sys_clk_en,
  input wire                         o_c1_clk_en,
  input wire                         o_c2_clk_en,
  input wire                         o_d1_req
);

  logic d1_busy;
  logic d1_set;

  // d1 group plus flash
  assign d1_busy = i_busy[rcc_pkg::BUSY_AXI_D1] || i_busy[rcc_pkg::BUSY_AHB3_D1] ||
                   i_busy[rcc_pkg::BUSY_APB3_D1] || i_busy[rcc_pkg::BUSY_FLASH];
  assign d1_set  = i_c1_deepsleep && (!i_c2_alloc_d1 || i_c2_deepsleep) && !d1_busy;

  // ========================================
  // reset ordering
  // ========================================
  a_cpu_after_sys: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_cpu1_rst_n || o_cpu2_rst_n) |-> o_sys_rst_n)
    else $error("cpu reset released while system reset held");

  // an enable needs its clock-on flag, which needs its reset
  a_clk_after_rst: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_sys_clk_en |-> o_sys_rst_n) and (o_c1_clk_en |-> o_cpu1_rst_n) and
    (o_c2_clk_en |-> o_cpu2_rst_n))
    else $error("clock enabled while its reset held");

  // request only rises after its set condition
  a_d1_req_cause: assert property (@(posedge i_clk) disable iff (i_reset)
    $rose(o_d1_req) |-> $past(d1_set))
    else $error("d1 stop request rose without set condition");

endmodule

`default_nettype wire

/* verification/rcc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rcc_tb;

  localparam int D1N   = rcc_pkg::D1_RST_CYCLES;
  localparam int D2N   = rcc_pkg::D2_RST_CYCLES;
  localparam int DLY   = rcc_pkg::CLK_ON_DELAY;
  localparam int DOMN  = (D1N > D2N) ? D1N : D2N;
  // reset, three reset waits, two delay waits, stop cases, random loop
  localparam int TEST_CYCLES = 16 + 3 * (DOMN + 4) + 2 * (DLY + 4) +
                               3 * (rcc_pkg::NUM_BUSY + 12) + 200;
  localparam int CYCLE_LIMIT = TEST_CYCLES + 100;

  logic i_clk, i_reset, i_nrst, i_por_rst, i_vcore_ok, i_obl_done, i_hsi_rdy;
  logic i_flash_power_ok, i_d1_ok, i_d2_ok, i_wwdg1_rst, i_wwdg2_rst, i_arcg_on;
  logic i_c1_sleep, i_c1_deepsleep, i_c2_sleep, i_c2_deepsleep, i_d3_deepsleep;
  logic i_c1_alloc_d2, i_c2_alloc_d1, i_d1_wkup, i_d2_wkup, i_d3_wkup;
  logic [rcc_pkg::NUM_BUSY-1:0]    i_busy;
  logic [rcc_pkg::NUM_ALLOC-1:0]   i_c1_alloc;
  logic [rcc_pkg::NUM_ALLOC-1:0]   i_c2_alloc;
  logic o_sys_rst_n, o_d1_rst_n, o_d2_rst_n, o_cpu1_rst_n, o_cpu2_rst_n;
  logic o_d1_bus_rst_n, o_d2_bus_rst_n, o_d3_bus_rst_n;
  logic o_d1_req, o_d2_req, o_d3_req, o_sys_clk_en, o_c1_clk_en, o_c2_clk_en;
  logic [rcc_pkg::NUM_BRIDGES-1:0] o_bridge_clk_en;

  int          bit_errs = 0;
  int          bridge_errs = 0;
  int          cycles = 0;
  logic [31:0] lfsr_q = 32'd67854;

  rcc_clk_rst_ctrl #(.D1_RST_CYCLES(D1N), .D2_RST_CYCLES(D2N), .CLK_ON_DELAY(DLY)) dut0 (.*);

  bind rcc_clk_rst_ctrl rcc_rst_chk chk0 (
    .i_clk(i_clk), .i_reset(i_reset), .i_c1_deepsleep(i_c1_deepsleep),
    .i_c2_deepsleep(i_c2_deepsleep), .i_c2_alloc_d1(i_c2_alloc_d1), .i_busy(i_busy),
    .o_sys_rst_n(o_sys_rst_n), .o_cpu1_rst_n(o_cpu1_rst_n), .o_cpu2_rst_n(o_cpu2_rst_n),
    .o_sys_clk_en(o_sys_clk_en), .o_c1_clk_en(o_c1_clk_en), .o_c2_clk_en(o_c2_clk_en),
    .o_d1_req(o_d1_req)
  );

  // ========================================
  // clock, timeout, helpers
  // ========================================
  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // taps 32 22 2 1
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = next_bit();
    end
    return v;
  endfunction

  // inputs change 1 ns after the edge
  task automatic tick();
    @(posedge i_clk);
    #1;
  endtask

  task automatic settle();
    #1;
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %b got %b", $time, name, exp, act);
      bit_errs++;
    end
  endtask

  task automatic check_bridges(input logic [rcc_pkg::NUM_BRIDGES-1:0] exp,
                               input logic [rcc_pkg::NUM_BRIDGES-1:0] act);
    if (act !== exp) begin
      $display("** Error at %0t: o_bridge_clk_en expected %b got %b", $time, exp, act);
      bridge_errs++;
    end
  endtask

  // bridge enables with both domain buses on
  function automatic logic [rcc_pkg::NUM_BRIDGES-1:0] expected_bridges(
    input logic c1s, input logic c1d, input logic c2s, input logic c2d,
    input logic [rcc_pkg::NUM_ALLOC-1:0] a1, input logic [rcc_pkg::NUM_ALLOC-1:0] a2,
    input logic [rcc_pkg::NUM_BUSY-1:0] b);
    logic [rcc_pkg::NUM_BRIDGES-1:0] e;
    logic sm1;
    logic sm2;
    sm1 = c1s && !c1d;
    sm2 = c2s && !c2d;
    e[rcc_pkg::BUSY_APB1_D2] = !c2s || (sm2 && a2[rcc_pkg::ALLOC_APB1]) ||
                               (sm1 && a1[rcc_pkg::ALLOC_APB1]) || b[rcc_pkg::BUSY_APB1_D2];
    e[rcc_pkg::BUSY_APB2_D2] = !c2s || (sm2 && a2[rcc_pkg::ALLOC_APB2]) ||
                               (sm1 && a1[rcc_pkg::ALLOC_APB2]) || b[rcc_pkg::BUSY_APB2_D2];
    e[rcc_pkg::BUSY_AHB2_D2] = !c2s || (sm2 && a2[rcc_pkg::ALLOC_AHB2]) ||
                               (sm1 && a1[rcc_pkg::ALLOC_AHB2]) || b[rcc_pkg::BUSY_AHB2_D2];
    e[rcc_pkg::BUSY_AHB1_D2] = !c2s || (sm2 && a2[rcc_pkg::ALLOC_AHB1]) ||
                               (sm1 && a1[rcc_pkg::ALLOC_AHB1]) || b[rcc_pkg::BUSY_AHB1_D2] ||
                               e[rcc_pkg::BUSY_APB1_D2] || e[rcc_pkg::BUSY_APB2_D2];
    e[rcc_pkg::BUSY_APB3_D1] = !c1s || (sm1 && a1[rcc_pkg::ALLOC_APB3]) ||
                               (sm2 && a2[rcc_pkg::ALLOC_APB3]) || b[rcc_pkg::BUSY_APB3_D1];
    e[rcc_pkg::BUSY_AHB3_D1] = !c1s || (sm1 && a1[rcc_pkg::ALLOC_AHB3]) ||
                               (sm2 && a2[rcc_pkg::ALLOC_AHB3]) || b[rcc_pkg::BUSY_AHB3_D1] ||
                               e[rcc_pkg::BUSY_APB3_D1] || b[rcc_pkg::BUSY_FLASH];
    e[rcc_pkg::BUSY_AXI_D1]  = !c1s || b[rcc_pkg::BUSY_AXI_D1];
    e[rcc_pkg::BUSY_AHB4_D3] = 1'b1;
    e[rcc_pkg::BUSY_APB4_D3] = 1'b1;
    return e;
  endfunction

  // ========================================
  // directed tests
  // ========================================
  task automatic test_reset_release();
    check_bit("o_sys_rst_n", 1'b0, o_sys_rst_n);
    i_por_rst = 1'b0;
    tick();
    check_bit("o_sys_rst_n", 1'b1, o_sys_rst_n);
    i_d1_ok = 1'b1;
    i_d2_ok = 1'b1;
    for (int n = 1; n <= DOMN + 1; n++) begin
      tick();
      check_bit("o_d1_rst_n", n >= D1N + 1, o_d1_rst_n);
      check_bit("o_d2_rst_n", n >= D2N + 1, o_d2_rst_n);
    end
    // no flash power holds d1 only
    i_d1_ok = 1'b0;
    i_d2_ok = 1'b0;
    i_flash_power_ok = 1'b0;
    tick();
    check_bit("o_sys_rst_n", 1'b0, o_sys_rst_n);
    i_d1_ok = 1'b1;
    i_d2_ok = 1'b1;
    for (int n = 1; n <= DOMN + 1; n++) begin
      tick();
      check_bit("o_d1_rst_n", 1'b0, o_d1_rst_n);
      check_bit("o_d2_rst_n", n >= D2N + 1, o_d2_rst_n);
    end
    i_flash_power_ok = 1'b1;
    tick();
    check_bit("o_d1_rst_n", 1'b1, o_d1_rst_n);
    check_bit("o_sys_rst_n", 1'b1, o_sys_rst_n);
  endtask

  task automatic test_clk_on_delay();
    i_wwdg1_rst = 1'b1;
    tick();
    check_bit("o_c1_clk_en", 1'b0, o_c1_clk_en);
    i_wwdg1_rst = 1'b0;
    settle();
    check_bit("o_cpu1_rst_n", 1'b1, o_cpu1_rst_n);
    for (int n = 1; n <= DLY; n++) begin
      tick();
      check_bit("o_c1_clk_en", n >= DLY, o_c1_clk_en);
    end
    // bypass follows the reset at once
    i_arcg_on = 1'b0;
    i_wwdg1_rst = 1'b1;
    // watchdog held over an edge so the delay counter restarts
    tick();
    check_bit("o_c1_clk_en", 1'b0, o_c1_clk_en);
    i_wwdg1_rst = 1'b0;
    settle();
    check_bit("o_c1_clk_en", 1'b1, o_c1_clk_en);
    i_nrst = 1'b0;
    tick();
    check_bit("o_sys_rst_n", 1'b0, o_sys_rst_n);
    check_bit("o_cpu1_rst_n", 1'b0, o_cpu1_rst_n);
    check_bit("o_cpu2_rst_n", 1'b0, o_cpu2_rst_n);
    check_bit("o_d1_bus_rst_n", 1'b0, o_d1_bus_rst_n);
    check_bit("o_d2_bus_rst_n", 1'b0, o_d2_bus_rst_n);
    check_bit("o_d3_bus_rst_n", 1'b0, o_d3_bus_rst_n);
    check_bit("o_sys_clk_en", 1'b0, o_sys_clk_en);
    check_bit("o_c1_clk_en", 1'b0, o_c1_clk_en);
    check_bit("o_c2_clk_en", 1'b0, o_c2_clk_en);
    i_nrst = 1'b1;
    tick();
    check_bit("o_sys_rst_n", 1'b1, o_sys_rst_n);
    check_bit("o_c1_clk_en", 1'b1, o_c1_clk_en);
  endtask

  task automatic test_wdg_bus_resets();
    i_wwdg1_rst = 1'b1;
    settle();
    check_bit("o_cpu1_rst_n", 1'b0, o_cpu1_rst_n);
    check_bit("o_cpu2_rst_n", 1'b1, o_cpu2_rst_n);
    check_bit("o_d1_bus_rst_n", 1'b1, o_d1_bus_rst_n);
    check_bit("o_d2_bus_rst_n", 1'b1, o_d2_bus_rst_n);
    i_wwdg1_rst = 1'b0;
    i_d2_ok = 1'b0;
    tick();
    check_bit("o_d2_bus_rst_n", 1'b0, o_d2_bus_rst_n);
    check_bit("o_cpu2_rst_n", 1'b0, o_cpu2_rst_n);
    check_bit("o_d1_bus_rst_n", 1'b1, o_d1_bus_rst_n);
    check_bit("o_d3_bus_rst_n", 1'b1, o_d3_bus_rst_n);
    i_d2_ok = 1'b1;
    repeat (D2N + 1) tick();
    check_bit("o_d2_bus_rst_n", 1'b1, o_d2_bus_rst_n);
    check_bit("o_cpu2_rst_n", 1'b1, o_cpu2_rst_n);
  endtask

  task automatic drive_stop(input int dom, input logic on);
    case (dom)
      0: i_c1_deepsleep = on;
      1: i_c2_deepsleep = on;
      default: begin
        i_c1_deepsleep = on;
        i_c2_deepsleep = on;
        i_d3_deepsleep = on;
      end
    endcase
  endtask

  task automatic drive_wkup(input int dom, input logic on);
    case (dom)
      0: i_d1_wkup = on;
      1: i_d2_wkup = on;
      default: i_d3_wkup = on;
    endcase
  endtask

  function automatic logic req_of(input int dom);
    return (dom == 0) ? o_d1_req : (dom == 1) ? o_d2_req : o_d3_req;
  endfunction

  task automatic stop_case(input int dom, input logic [rcc_pkg::NUM_BUSY-1:0] mask);
    string nm;
    nm = $sformatf("o_d%0d_req", dom + 1);
    drive_stop(dom, 1'b1);
    // each busy bit of the group blocks the request
    for (int b = 0; b < rcc_pkg::NUM_BUSY; b++) begin
      if (mask[b]) begin
        i_busy = '0;
        i_busy[b] = 1'b1;
        tick();
        check_bit(nm, 1'b0, req_of(dom));
      end
    end
    i_busy = '0;
    tick();
    check_bit(nm, 1'b1, req_of(dom));
    // pending request turns the domain's bridges off
    check_bridges(~mask[rcc_pkg::NUM_BRIDGES-1:0], o_bridge_clk_en);
    if (dom == 2) check_bit("o_sys_clk_en", 1'b0, o_sys_clk_en);
    drive_stop(dom, 1'b0);
    repeat (3) begin
      tick();
      check_bit(nm, 1'b1, req_of(dom));
    end
    drive_wkup(dom, 1'b1);
    tick();
    check_bit(nm, 1'b0, req_of(dom));
    // set beats wakeup
    drive_stop(dom, 1'b1);
    tick();
    check_bit(nm, 1'b1, req_of(dom));
    drive_stop(dom, 1'b0);
    tick();
    check_bit(nm, 1'b0, req_of(dom));
    // clear whatever else got raised
    i_d1_wkup = 1'b1;
    i_d2_wkup = 1'b1;
    i_d3_wkup = 1'b1;
    tick();
    i_d1_wkup = 1'b0;
    i_d2_wkup = 1'b0;
    i_d3_wkup = 1'b0;
  endtask

  task automatic test_stop_handshake();
    logic [rcc_pkg::NUM_BUSY-1:0] m1;
    logic [rcc_pkg::NUM_BUSY-1:0] m2;
    m1 = '0;
    m2 = '0;
    m1[rcc_pkg::BUSY_AXI_D1] = 1'b1;
    m1[rcc_pkg::BUSY_AHB3_D1] = 1'b1;
    m1[rcc_pkg::BUSY_APB3_D1] = 1'b1;
    m1[rcc_pkg::BUSY_FLASH] = 1'b1;
    m2[rcc_pkg::BUSY_AHB1_D2] = 1'b1;
    m2[rcc_pkg::BUSY_AHB2_D2] = 1'b1;
    m2[rcc_pkg::BUSY_APB1_D2] = 1'b1;
    m2[rcc_pkg::BUSY_APB2_D2] = 1'b1;
    // awake c2 owning d1 blocks the d1 stop
    i_c2_alloc_d1 = 1'b1;
    i_c1_deepsleep = 1'b1;
    tick();
    tick();
    check_bit("o_d1_req", 1'b0, o_d1_req);
    i_c1_deepsleep = 1'b0;
    i_c2_alloc_d1 = 1'b0;
    tick();
    stop_case(0, m1);
    stop_case(1, m2);
    stop_case(2, '1);
  endtask

  task automatic test_bridge_enables();
    logic [rcc_pkg::NUM_BRIDGES-1:0] exp;
    logic [15:0]                     r;
    // cross allocation keeps every stop request clear
    i_c1_alloc_d2 = 1'b1;
    i_c2_alloc_d1 = 1'b1;
    for (int i = 0; i < 200; i++) begin
      i_c1_sleep = next_bit();
      i_c1_deepsleep = next_bit();
      i_c2_sleep = next_bit();
      i_c2_deepsleep = next_bit();
      if (i_c1_deepsleep && i_c2_deepsleep) i_c2_deepsleep = 1'b0;
      r = rand_bits(rcc_pkg::NUM_ALLOC);
      i_c1_alloc = r[rcc_pkg::NUM_ALLOC-1:0];
      r = rand_bits(rcc_pkg::NUM_ALLOC);
      i_c2_alloc = r[rcc_pkg::NUM_ALLOC-1:0];
      r = rand_bits(rcc_pkg::NUM_BUSY);
      i_busy = r[rcc_pkg::NUM_BUSY-1:0];
      settle();
      exp = expected_bridges(i_c1_sleep, i_c1_deepsleep, i_c2_sleep, i_c2_deepsleep,
                             i_c1_alloc, i_c2_alloc, i_busy);
      check_bridges(exp, o_bridge_clk_en);
      check_bit("o_c1_clk_en", !i_c1_sleep && !i_c1_deepsleep, o_c1_clk_en);
      check_bit("o_c2_clk_en", !i_c2_sleep && !i_c2_deepsleep, o_c2_clk_en);
      check_bit("o_sys_clk_en", 1'b1, o_sys_clk_en);
      tick();
    end
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    i_reset = 1'b1;
    i_nrst = 1'b1;
    i_por_rst = 1'b1;
    i_vcore_ok = 1'b1;
    i_obl_done = 1'b1;
    i_hsi_rdy = 1'b1;
    i_flash_power_ok = 1'b1;
    i_d1_ok = 1'b0;
    i_d2_ok = 1'b0;
    i_wwdg1_rst = 1'b0;
    i_wwdg2_rst = 1'b0;
    i_arcg_on = 1'b1;
    i_c1_sleep = 1'b0;
    i_c1_deepsleep = 1'b0;
    i_c2_sleep = 1'b0;
    i_c2_deepsleep = 1'b0;
    i_d3_deepsleep = 1'b0;
    i_c1_alloc_d2 = 1'b0;
    i_c2_alloc_d1 = 1'b0;
    i_d1_wkup = 1'b0;
    i_d2_wkup = 1'b0;
    i_d3_wkup = 1'b0;
    i_busy = '0;
    i_c1_alloc = '0;
    i_c2_alloc = '0;
    repeat (16) @(posedge i_clk);
    #1;
    i_reset = 1'b0;
    test_reset_release();
    test_clk_on_delay();
    test_wdg_bus_resets();
    test_stop_handshake();
    test_bridge_enables();
    $display("errors: bit checks %0d, bridge checks %0d", bit_errs, bridge_errs);
    if (bit_errs == 0 && bridge_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
